// File: design/la32_pkg.sv
package la32_pkg;

    // one instruction word seen through each LA32 encoding format
    typedef struct packed {
        logic [5:0] op_31_26;
        logic [3:0] op_25_22;
        logic [1:0] op_21_20;
        logic [4:0] op_19_15;
        logic [4:0] rk;
        logic [4:0] rj;
        logic [4:0] rd;
    } r3_t;

    typedef struct packed {
        logic [9:0]  op;
        logic [11:0] si12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } ri12_t;

    typedef struct packed {
        logic [6:0]  op;
        logic [19:0] si20;
        logic [4:0]  rd;
    } ri20_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [15:0] offs16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } ri16_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [15:0] offs_lo;   // offs[15:0]
        logic [9:0]  offs_hi;   // offs[25:16] sits in the low bits of the word
    } i26_t;

    typedef union packed {
        r3_t   r3;
        ri12_t ri12;
        ri20_t ri20;
        ri16_t ri16;
        i26_t  i26;
    } inst_t;

    // one-hot ALU operation word
    localparam int OP_ALU_W = 12;
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // 3R and shift-by-immediate groups share the top six bits
    localparam logic [5:0] OP6_ALU   = 6'h00;
    localparam logic [3:0] OP4_R3    = 4'h0;
    localparam logic [1:0] OP2_R3    = 2'h1;
    localparam logic [3:0] OP4_SHIFT = 4'h1;
    localparam logic [1:0] OP2_SHIFT = 2'h0;

    localparam logic [4:0] OP5_ADD_W  = 5'h00;
    localparam logic [4:0] OP5_SUB_W  = 5'h02;
    localparam logic [4:0] OP5_SLT    = 5'h04;
    localparam logic [4:0] OP5_SLTU   = 5'h05;
    localparam logic [4:0] OP5_NOR    = 5'h08;
    localparam logic [4:0] OP5_AND    = 5'h09;
    localparam logic [4:0] OP5_OR     = 5'h0a;
    localparam logic [4:0] OP5_XOR    = 5'h0b;
    localparam logic [4:0] OP5_SLLI_W = 5'h01;
    localparam logic [4:0] OP5_SRLI_W = 5'h09;
    localparam logic [4:0] OP5_SRAI_W = 5'h11;

    localparam logic [9:0] OP10_ADDI_W = 10'h00a;
    localparam logic [9:0] OP10_LD_W   = 10'h0a2;
    localparam logic [9:0] OP10_ST_W   = 10'h0a6;
    localparam logic [6:0] OP7_LU12I_W = 7'h0a;

    localparam logic [5:0] OP6_JIRL = 6'h13;
    localparam logic [5:0] OP6_B    = 6'h14;
    localparam logic [5:0] OP6_BL   = 6'h15;
    localparam logic [5:0] OP6_BEQ  = 6'h16;
    localparam logic [5:0] OP6_BNE  = 6'h17;

    // kind of control transfer resolved in EXEC
    localparam logic [1:0] BR_NONE = 2'd0;
    localparam logic [1:0] BR_BEQ  = 2'd1;
    localparam logic [1:0] BR_BNE  = 2'd2;
    localparam logic [1:0] BR_JUMP = 2'd3;

endpackage

// File: design/core_ifs.sv
`timescale 1ns/1ps

interface rf_if;
    logic [4:0]  raddr1;
    logic [31:0] rdata1;
    logic [4:0]  raddr2;
    logic [31:0] rdata2;
    logic        we;
    logic [4:0]  waddr;
    logic [31:0] wdata;

    modport master (output raddr1, raddr2, we, waddr, wdata, input rdata1, rdata2);
    modport slave  (input raddr1, raddr2, we, waddr, wdata, output rdata1, rdata2);
endinterface

interface dec_if;
    import la32_pkg::*;

    logic [OP_ALU_W-1:0] alu_op;
    logic        src1_is_pc;
    logic        src2_is_imm;
    logic        src_reg_is_rd;
    logic        res_from_mem;
    logic        mem_we;
    logic        gr_we;
    logic [4:0]  dest;
    logic [31:0] imm;
    logic [31:0] br_offs;
    logic [31:0] jirl_offs;
    logic [1:0]  br_kind;

    modport source (output alu_op, src1_is_pc, src2_is_imm, src_reg_is_rd, res_from_mem,
                    mem_we, gr_we, dest, imm, br_offs, jirl_offs, br_kind);
    modport sink   (input alu_op, src1_is_pc, src2_is_imm, src_reg_is_rd, res_from_mem,
                    mem_we, gr_we, dest, imm, br_offs, jirl_offs, br_kind);
endinterface

// File: design/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [la32_pkg::OP_ALU_W-1:0] alu_op,
    input  logic [31:0]                   alu_src1,
    input  logic [31:0]                   alu_src2,
    output logic [31:0]                   alu_result
);
    import la32_pkg::*;

    logic        do_sub;
    logic [31:0] adder_b;
    logic [32:0] adder_sum;
    logic        slt_res;
    logic        sltu_res;
    logic [31:0] sll_res;
    logic [31:0] srl_res;
    logic [31:0] sra_res;

    // add, sub and both compares share one adder
    assign do_sub    = alu_op[ALU_SUB] | alu_op[ALU_SLT] | alu_op[ALU_SLTU];
    assign adder_b   = do_sub ? ~alu_src2 : alu_src2;
    assign adder_sum = {1'b0, alu_src1} + {1'b0, adder_b} + {32'd0, do_sub};

    assign slt_res  = (alu_src1[31] & ~alu_src2[31])
                    | (~(alu_src1[31] ^ alu_src2[31]) & adder_sum[31]);
    assign sltu_res = ~adder_sum[32];   // no carry out means src1 < src2

    assign sll_res = alu_src1 << alu_src2[4:0];
    assign srl_res = alu_src1 >> alu_src2[4:0];
    assign sra_res = $signed(alu_src1) >>> alu_src2[4:0];

    assign alu_result = ({32{alu_op[ALU_ADD] | alu_op[ALU_SUB]}} & adder_sum[31:0])
                      | ({32{alu_op[ALU_SLT]}}  & {31'd0, slt_res})
                      | ({32{alu_op[ALU_SLTU]}} & {31'd0, sltu_res})
                      | ({32{alu_op[ALU_AND]}}  & (alu_src1 & alu_src2))
                      | ({32{alu_op[ALU_NOR]}}  & ~(alu_src1 | alu_src2))
                      | ({32{alu_op[ALU_OR]}}   & (alu_src1 | alu_src2))
                      | ({32{alu_op[ALU_XOR]}}  & (alu_src1 ^ alu_src2))
                      | ({32{alu_op[ALU_SLL]}}  & sll_res)
                      | ({32{alu_op[ALU_SRL]}}  & srl_res)
                      | ({32{alu_op[ALU_SRA]}}  & sra_res)
                      | ({32{alu_op[ALU_LUI]}}  & alu_src2);

endmodule

// File: design/regfile.sv
`timescale 1ns/1ps

module regfile (
    input logic clk,
    rf_if.slave rf
);

    logic [31:0] regs [1:31];   // r0 has no storage

    always_ff @(posedge clk) begin
        if (rf.we && rf.waddr != 5'd0) begin
            regs[rf.waddr] <= rf.wdata;
        end
    end

    // reads see the old value during a same-cycle write
    always_comb begin
        if (rf.raddr1 == 5'd0) begin
            rf.rdata1 = 32'd0;
        end else begin
            rf.rdata1 = regs[rf.raddr1];
        end
    end

    always_comb begin
        if (rf.raddr2 == 5'd0) begin
            rf.rdata2 = 32'd0;
        end else begin
            rf.rdata2 = regs[rf.raddr2];
        end
    end

endmodule

// File: design/inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
    input  la32_pkg::inst_t ir,
    dec_if.source           dec
);
    import la32_pkg::*;

    logic is_r3;
    logic is_shift;
    logic inst_add_w;
    logic inst_sub_w;
    logic inst_slt;
    logic inst_sltu;
    logic inst_nor;
    logic inst_and;
    logic inst_or;
    logic inst_xor;
    logic inst_slli_w;
    logic inst_srli_w;
    logic inst_srai_w;
    logic inst_addi_w;
    logic inst_lu12i_w;
    logic inst_ld_w;
    logic inst_st_w;
    logic inst_jirl;
    logic inst_b;
    logic inst_bl;
    logic inst_beq;
    logic inst_bne;
    logic inst_known;
    logic need_ui5;
    logic need_si12;
    logic need_si20;
    logic need_si26;
    logic src2_is_4;
    logic [OP_ALU_W-1:0] op;

    assign is_r3    = ir.r3.op_31_26 == OP6_ALU && ir.r3.op_25_22 == OP4_R3
                      && ir.r3.op_21_20 == OP2_R3;
    assign is_shift = ir.r3.op_31_26 == OP6_ALU && ir.r3.op_25_22 == OP4_SHIFT
                      && ir.r3.op_21_20 == OP2_SHIFT;

    assign inst_add_w   = is_r3 && ir.r3.op_19_15 == OP5_ADD_W;
    assign inst_sub_w   = is_r3 && ir.r3.op_19_15 == OP5_SUB_W;
    assign inst_slt     = is_r3 && ir.r3.op_19_15 == OP5_SLT;
    assign inst_sltu    = is_r3 && ir.r3.op_19_15 == OP5_SLTU;
    assign inst_nor     = is_r3 && ir.r3.op_19_15 == OP5_NOR;
    assign inst_and     = is_r3 && ir.r3.op_19_15 == OP5_AND;
    assign inst_or      = is_r3 && ir.r3.op_19_15 == OP5_OR;
    assign inst_xor     = is_r3 && ir.r3.op_19_15 == OP5_XOR;
    assign inst_slli_w  = is_shift && ir.r3.op_19_15 == OP5_SLLI_W;
    assign inst_srli_w  = is_shift && ir.r3.op_19_15 == OP5_SRLI_W;
    assign inst_srai_w  = is_shift && ir.r3.op_19_15 == OP5_SRAI_W;
    assign inst_addi_w  = ir.ri12.op == OP10_ADDI_W;
    assign inst_ld_w    = ir.ri12.op == OP10_LD_W;
    assign inst_st_w    = ir.ri12.op == OP10_ST_W;
    assign inst_lu12i_w = ir.ri20.op == OP7_LU12I_W;
    assign inst_jirl    = ir.ri16.op == OP6_JIRL;
    assign inst_b       = ir.ri16.op == OP6_B;
    assign inst_bl      = ir.ri16.op == OP6_BL;
    assign inst_beq     = ir.ri16.op == OP6_BEQ;
    assign inst_bne     = ir.ri16.op == OP6_BNE;

    assign inst_known = is_r3 && (inst_add_w || inst_sub_w || inst_slt || inst_sltu
                                  || inst_nor || inst_and || inst_or || inst_xor)
                        || inst_slli_w || inst_srli_w || inst_srai_w
                        || inst_addi_w || inst_lu12i_w || inst_ld_w || inst_st_w
                        || inst_jirl || inst_b || inst_bl || inst_beq || inst_bne;

    // link instructions use the adder to form pc + 4
    always_comb begin
        op = '0;
        op[ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w | inst_jirl | inst_bl;
        op[ALU_SUB]  = inst_sub_w;
        op[ALU_SLT]  = inst_slt;
        op[ALU_SLTU] = inst_sltu;
        op[ALU_AND]  = inst_and;
        op[ALU_NOR]  = inst_nor;
        op[ALU_OR]   = inst_or;
        op[ALU_XOR]  = inst_xor;
        op[ALU_SLL]  = inst_slli_w;
        op[ALU_SRL]  = inst_srli_w;
        op[ALU_SRA]  = inst_srai_w;
        op[ALU_LUI]  = inst_lu12i_w;
    end
    assign dec.alu_op = op;

    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si12 = inst_addi_w | inst_ld_w | inst_st_w;
    assign need_si20 = inst_lu12i_w;
    assign need_si26 = inst_b | inst_bl;
    assign src2_is_4 = inst_jirl | inst_bl;

    // shift amounts live in si12[4:0] and the sign bit there is always 0
    assign dec.imm = src2_is_4 ? 32'd4
                   : need_si20 ? {ir.ri20.si20, 12'd0}
                   : {{20{ir.ri12.si12[11]}}, ir.ri12.si12};

    assign dec.br_offs = need_si26
        ? {{4{ir.i26.offs_hi[9]}}, ir.i26.offs_hi, ir.i26.offs_lo, 2'b00}
        : {{14{ir.ri16.offs16[15]}}, ir.ri16.offs16, 2'b00};
    assign dec.jirl_offs = {{14{ir.ri16.offs16[15]}}, ir.ri16.offs16, 2'b00};

    assign dec.src1_is_pc    = inst_jirl | inst_bl | inst_b;
    assign dec.src2_is_imm   = need_ui5 | need_si12 | need_si20 | src2_is_4 | inst_b;
    assign dec.src_reg_is_rd = inst_beq | inst_bne | inst_st_w;
    assign dec.res_from_mem  = inst_ld_w;
    assign dec.mem_we        = inst_st_w;
    assign dec.gr_we         = inst_known & ~inst_st_w & ~inst_beq & ~inst_bne & ~inst_b;
    assign dec.dest          = inst_bl ? 5'd1 : ir.r3.rd;

    assign dec.br_kind = inst_beq ? BR_BEQ
                       : inst_bne ? BR_BNE
                       : (inst_b | inst_bl | inst_jirl) ? BR_JUMP
                       : BR_NONE;

endmodule

// File: design/la32_core.sv
`timescale 1ns/1ps

module la32_core #(
    parameter logic [31:0] RESET_PC = 32'h1c000000
) (
    input  logic        clk,
    input  logic        reset,
    output logic        inst_sram_we,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    import la32_pkg::*;

    localparam logic [2:0] S_FETCH  = 3'd0;
    localparam logic [2:0] S_DECODE = 3'd1;
    localparam logic [2:0] S_EXEC   = 3'd2;
    localparam logic [2:0] S_MEM    = 3'd3;
    localparam logic [2:0] S_WB     = 3'd4;

    logic [2:0]  state;
    logic [31:0] pc;
    logic [31:0] seq_pc;
    inst_t       ir;
    inst_t       cur_inst;
    logic [31:0] rj_val;
    logic [31:0] rkd_val;
    logic [31:0] alu_src1;
    logic [31:0] alu_src2;
    logic [31:0] alu_result;
    logic [31:0] alu_res;
    logic        rj_eq_rd;
    logic        taken;
    logic        br_taken;
    logic [31:0] br_target;
    logic [31:0] wb_data;
    logic        wb_we;
    logic [31:0] retired_pc;

    rf_if  rf_bus ();
    dec_if dec_bus ();

    // the word arrives from the SRAM during DECODE, so the decoder sees it before ir does
    assign cur_inst = (state == S_DECODE) ? inst_t'(inst_sram_rdata) : ir;

    inst_decode u_decode (
        .ir  (cur_inst),
        .dec (dec_bus.source)
    );

    regfile u_regfile (
        .clk (clk),
        .rf  (rf_bus.slave)
    );

    alu u_alu (
        .alu_op     (dec_bus.alu_op),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_FETCH;
        end else begin
            case (state)
                S_FETCH:  state <= S_DECODE;
                S_DECODE: state <= S_EXEC;
                S_EXEC:   state <= (dec_bus.mem_we || dec_bus.res_from_mem) ? S_MEM : S_WB;
                S_MEM:    state <= S_WB;
                S_WB:     state <= S_FETCH;
                default:  state <= S_FETCH;
            endcase
        end
    end

    assign seq_pc = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (state == S_WB) begin
            pc <= br_taken ? br_target : seq_pc;
        end
    end

    assign inst_sram_we    = 1'b0;
    assign inst_sram_addr  = pc;
    assign inst_sram_wdata = 32'd0;

    assign rf_bus.raddr1 = cur_inst.r3.rj;
    assign rf_bus.raddr2 = dec_bus.src_reg_is_rd ? cur_inst.r3.rd : cur_inst.r3.rk;

    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            ir      <= inst_sram_rdata;
            rj_val  <= rf_bus.rdata1;
            rkd_val <= rf_bus.rdata2;
        end
    end

    assign alu_src1 = dec_bus.src1_is_pc ? pc : rj_val;
    assign alu_src2 = dec_bus.src2_is_imm ? dec_bus.imm : rkd_val;

    assign rj_eq_rd = rj_val == rkd_val;
    assign taken = (dec_bus.br_kind == BR_JUMP)
                || (dec_bus.br_kind == BR_BEQ && rj_eq_rd)
                || (dec_bus.br_kind == BR_BNE && !rj_eq_rd);

    always_ff @(posedge clk) begin
        if (reset) begin
            br_taken <= 1'b0;
        end else if (state == S_EXEC) begin
            br_taken <= taken;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_EXEC) begin
            alu_res <= alu_result;
            if (ir.ri16.op == OP6_JIRL) begin
                br_target <= rj_val + dec_bus.jirl_offs;
            end else begin
                br_target <= pc + dec_bus.br_offs;
            end
        end
    end

    assign data_sram_we    = (state == S_MEM) && dec_bus.mem_we;   // one pulse per store
    assign data_sram_addr  = alu_res;
    assign data_sram_wdata = rkd_val;

    // load data is back from the SRAM by WB
    assign wb_data = dec_bus.res_from_mem ? data_sram_rdata : alu_res;
    assign wb_we   = (state == S_WB) && dec_bus.gr_we && dec_bus.dest != 5'd0;

    assign rf_bus.we    = wb_we;
    assign rf_bus.waddr = dec_bus.dest;
    assign rf_bus.wdata = wb_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            retired_pc <= 32'd0;
        end else if (state == S_WB) begin
            retired_pc <= pc;
        end
    end

    assign debug_wb_pc       = (state == S_WB) ? pc : retired_pc;
    assign debug_wb_rf_we    = {4{wb_we}};
    assign debug_wb_rf_wnum  = dec_bus.dest;
    assign debug_wb_rf_wdata = wb_data;

endmodule

// File: bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    // reset is let go on a falling edge, like every other input
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: bench/la32_assert.sv
`timescale 1ns/1ps

module la32_assert (
    input logic       clk,
    input logic       reset,
    input logic       inst_sram_we,
    input logic       data_sram_we,
    input logic [3:0] debug_wb_rf_we
);

    int fail_count = 0;   // read by the testbench at the end of the run

    inst_we_low: assert property (@(posedge clk) disable iff (reset) !inst_sram_we)
        else begin
            fail_count++;
            $error("instruction SRAM write enable went high");
        end

    // a store is one MEM cycle, so the pulse never lasts two cycles
    store_single_pulse: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |=> !data_sram_we)
        else begin
            fail_count++;
            $error("data SRAM write enable stayed high for two cycles");
        end

    trace_we_bits_equal: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we == {4{debug_wb_rf_we[0]}})
        else begin
            fail_count++;
            $error("trace write enable bits differ: %b", debug_wb_rf_we);
        end

endmodule

bind la32_core la32_assert u_la32_assert (.*);

// File: bench/tb_la32.sv
`timescale 1ns/1ps

module tb_la32;
    import la32_pkg::*;

    localparam logic [31:0] RESET_PC = 32'h1c000000;
    localparam int N_STEPS = 32;
    localparam int WATCHDOG_CYCLES = N_STEPS * 5 + 20;

    logic        clk;
    logic        reset;
    logic        inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata = 32'd0;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata = 32'd0;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] inst_mem [0:255];
    logic [31:0] data_mem [0:255];

    // one entry per retirement with the word placed at its pc and wnum 0 for no register write
    inst_t       prog_word [N_STEPS];
    logic [31:0] exp_pc    [N_STEPS];
    logic [4:0]  exp_wnum  [N_STEPS];
    logic [31:0] exp_wdata [N_STEPS];

    logic [31:0] lfsr = 32'haf2b_d3b7;
    logic [31:0] last_pc = 32'd0;
    int          n_steps = 0;
    int          errors = 0;
    int          checked = 0;
    int          assert_fails = 0;

    clock_gen u_clock (.clk(clk), .reset(reset));

    la32_core #(.RESET_PC(RESET_PC)) uut (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_we      (inst_sram_we),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    // read data follows the address half a cycle later and holds through the next cycle
    always @(negedge clk) begin
        inst_sram_rdata <= inst_mem[inst_sram_addr[9:2]];
        data_sram_rdata <= data_mem[data_sram_addr[9:2]];
        if (data_sram_we) begin
            data_mem[data_sram_addr[9:2]] <= data_sram_wdata;
        end
    end

    function automatic inst_t r3_word(input logic [4:0] op5, input logic [4:0] rk,
                                      input logic [4:0] rj, input logic [4:0] rd);
        inst_t w;
        w.r3 = {OP6_ALU, OP4_R3, OP2_R3, op5, rk, rj, rd};
        return w;
    endfunction

    function automatic inst_t shift_word(input logic [4:0] op5, input logic [4:0] ui5,
                                         input logic [4:0] rj, input logic [4:0] rd);
        inst_t w;
        w.r3 = {OP6_ALU, OP4_SHIFT, OP2_SHIFT, op5, ui5, rj, rd};
        return w;
    endfunction

    function automatic inst_t ri12_word(input logic [9:0] op10, input logic [11:0] si12,
                                        input logic [4:0] rj, input logic [4:0] rd);
        inst_t w;
        w.ri12 = {op10, si12, rj, rd};
        return w;
    endfunction

    function automatic inst_t lu12i_word(input logic [19:0] si20, input logic [4:0] rd);
        inst_t w;
        w.ri20 = {OP7_LU12I_W, si20, rd};
        return w;
    endfunction

    function automatic inst_t ri16_word(input logic [5:0] op6, input logic [15:0] offs16,
                                        input logic [4:0] rj, input logic [4:0] rd);
        inst_t w;
        w.ri16 = {op6, offs16, rj, rd};
        return w;
    endfunction

    function automatic inst_t i26_word(input logic [5:0] op6, input logic [25:0] offs26);
        inst_t w;
        w.i26 = {op6, offs26[15:0], offs26[25:16]};   // high offset bits go at the bottom
        return w;
    endfunction

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic fill_data_mem();
        logic [31:0] w;
        for (int i = 0; i < 256; i++) begin
            w = 32'd0;
            for (int b = 0; b < 32; b++) begin
                lfsr = lfsr_step(lfsr);
                w = {w[30:0], lfsr[0]};
            end
            data_mem[i] = w;
        end
    endtask

    task automatic add_step(input inst_t w, input logic [31:0] offs, input logic [4:0] wnum,
                            input logic [31:0] wdata);
        prog_word[n_steps] = w;
        exp_pc[n_steps]    = RESET_PC + offs;
        exp_wnum[n_steps]  = wnum;
        exp_wdata[n_steps] = wdata;
        n_steps++;
    endtask

    task automatic build_program();
        add_step(ri12_word(OP10_ADDI_W, 12'h123, 5'd0, 5'd1), 32'h00, 5'd1, 32'h0000_0123);
        add_step(ri12_word(OP10_ADDI_W, 12'hffb, 5'd0, 5'd2), 32'h04, 5'd2, 32'hffff_fffb);
        add_step(lu12i_word(20'h80001, 5'd3), 32'h08, 5'd3, 32'h8000_1000);
        add_step(ri12_word(OP10_ADDI_W, 12'h7ff, 5'd3, 5'd3), 32'h0c, 5'd3, 32'h8000_17ff);
        add_step(r3_word(OP5_ADD_W, 5'd2, 5'd1, 5'd4), 32'h10, 5'd4, 32'h0000_011e);
        add_step(r3_word(OP5_SUB_W, 5'd2, 5'd1, 5'd5), 32'h14, 5'd5, 32'h0000_0128);
        add_step(r3_word(OP5_SLT, 5'd1, 5'd2, 5'd6), 32'h18, 5'd6, 32'h0000_0001);
        add_step(r3_word(OP5_SLTU, 5'd1, 5'd2, 5'd7), 32'h1c, 5'd7, 32'h0000_0000);
        add_step(r3_word(OP5_SLT, 5'd2, 5'd3, 5'd8), 32'h20, 5'd8, 32'h0000_0001);
        add_step(r3_word(OP5_NOR, 5'd2, 5'd1, 5'd9), 32'h24, 5'd9, 32'h0000_0004);
        add_step(r3_word(OP5_AND, 5'd3, 5'd1, 5'd10), 32'h28, 5'd10, 32'h0000_0123);
        add_step(r3_word(OP5_OR, 5'd3, 5'd1, 5'd11), 32'h2c, 5'd11, 32'h8000_17ff);
        add_step(r3_word(OP5_XOR, 5'd3, 5'd1, 5'd12), 32'h30, 5'd12, 32'h8000_16dc);
        add_step(shift_word(OP5_SLLI_W, 5'd4, 5'd1, 5'd13), 32'h34, 5'd13, 32'h0000_1230);
        add_step(shift_word(OP5_SRLI_W, 5'd8, 5'd3, 5'd14), 32'h38, 5'd14, 32'h0080_0017);
        add_step(shift_word(OP5_SRAI_W, 5'd8, 5'd3, 5'd15), 32'h3c, 5'd15, 32'hff80_0017);
        add_step(lu12i_word(20'hfffff, 5'd16), 32'h40, 5'd16, 32'hffff_f000);
        add_step(ri12_word(OP10_ADDI_W, 12'h005, 5'd1, 5'd0), 32'h44, 5'd0, 32'h0);
        add_step(r3_word(OP5_ADD_W, 5'd1, 5'd0, 5'd17), 32'h48, 5'd17, 32'h0000_0123);
        add_step(ri12_word(OP10_ADDI_W, 12'h100, 5'd0, 5'd20), 32'h4c, 5'd20, 32'h0000_0100);
        add_step(ri12_word(OP10_ST_W, 12'h000, 5'd20, 5'd3), 32'h50, 5'd0, 32'h0);
        add_step(ri12_word(OP10_LD_W, 12'h000, 5'd20, 5'd18), 32'h54, 5'd18, 32'h8000_17ff);
        add_step(ri12_word(OP10_LD_W, 12'h008, 5'd20, 5'd19), 32'h58, 5'd19, data_mem[8'h42]);
        // r1 equals r10 but not r2
        add_step(ri16_word(OP6_BEQ, 16'd2, 5'd1, 5'd10), 32'h5c, 5'd0, 32'h0);
        add_step(ri16_word(OP6_BNE, 16'd2, 5'd1, 5'd10), 32'h64, 5'd0, 32'h0);
        add_step(ri16_word(OP6_BNE, 16'd3, 5'd1, 5'd2), 32'h68, 5'd0, 32'h0);
        add_step(ri16_word(OP6_BEQ, 16'd2, 5'd1, 5'd2), 32'h74, 5'd0, 32'h0);
        add_step(i26_word(OP6_BL, 26'd3), 32'h78, 5'd1, RESET_PC + 32'h7c);
        add_step(i26_word(OP6_B, 26'd2), 32'h84, 5'd0, 32'h0);
        add_step(lu12i_word(RESET_PC[31:12], 5'd21), 32'h8c, 5'd21, RESET_PC);
        add_step(ri16_word(OP6_JIRL, 16'h0028, 5'd21, 5'd22), 32'h90, 5'd22, RESET_PC + 32'h94);
        add_step(i26_word(OP6_B, 26'd0), 32'ha0, 5'd0, 32'h0);   // self-loop ends the program
    endtask

    // unused words decode to no-ops, so a wrong jump only shows in the pc sequence
    task automatic load_program();
        for (int i = 0; i < 256; i++) begin
            inst_mem[i] = ~(RESET_PC + (i << 2));
        end
        for (int k = 0; k < n_steps; k++) begin
            inst_mem[exp_pc[k][9:2]] = prog_word[k];
        end
    endtask

    task automatic pc_compare(input logic [31:0] got, input logic [31:0] exp, input int step);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] time %0d ns: step %0d retired pc %h, expected %h",
                     $time, step, got, exp);
        end
    endtask

    task automatic we_compare(input logic [3:0] got, input logic [3:0] exp, input int step);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] time %0d ns: step %0d write enable %h, expected %h",
                     $time, step, got, exp);
        end
    endtask

    task automatic wnum_compare(input logic [4:0] got, input logic [4:0] exp, input int step);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] time %0d ns: step %0d wrote r%0d, expected r%0d",
                     $time, step, got, exp);
        end
    endtask

    task automatic data_compare(input logic [31:0] got, input logic [31:0] exp, input int step);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] time %0d ns: step %0d write data %h, expected %h",
                     $time, step, got, exp);
        end
    endtask

    task automatic fetch_wdata_compare(input logic [31:0] got, input int step);
        if (got !== 32'd0) begin
            errors++;
            $display("[FAIL] time %0d ns: step %0d instruction SRAM write data %h, expected 0",
                     $time, step, got);
        end
    endtask

    // a retirement shows as a new value on debug_wb_pc at the falling edge inside WB
    task automatic wait_retirement(input logic first);
        @(negedge clk);
        while (debug_wb_pc === last_pc) begin
            if (first && (debug_wb_rf_we !== 4'h0 || data_sram_we !== 1'b0)) begin
                errors++;
                $display("[FAIL] time %0d ns: register write or store before the first retirement",
                         $time);
            end
            @(negedge clk);
        end
        last_pc = debug_wb_pc;
    endtask

    task automatic check_step(input int i);
        pc_compare(debug_wb_pc, exp_pc[i], i);
        fetch_wdata_compare(inst_sram_wdata, i);
        if (exp_wnum[i] == 5'd0) begin
            we_compare(debug_wb_rf_we, 4'h0, i);
        end else begin
            we_compare(debug_wb_rf_we, 4'hf, i);
            wnum_compare(debug_wb_rf_wnum, exp_wnum[i], i);
            data_compare(debug_wb_rf_wdata, exp_wdata[i], i);
        end
        checked++;
    endtask

    initial begin
        fill_data_mem();
        build_program();
        load_program();
        wait (reset == 1'b0);
        for (int i = 0; i < n_steps; i++) begin
            wait_retirement(i == 0);
            check_step(i);
        end
        assert_fails = uut.u_la32_assert.fail_count;
        $display("errors: %0d, assertion failures: %0d, retirements checked: %0d",
                 errors, assert_fails, checked);
        if (errors == 0 && assert_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the core stopped retiring after %0d of %0d steps", checked, n_steps);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: tb.f
design/la32_pkg.sv
design/core_ifs.sv
design/alu.sv
design/regfile.sv
design/inst_decode.sv
design/la32_core.sv
bench/clock_gen.sv
bench/la32_assert.sv
bench/tb_la32.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module tb_la32 -Mdir obj_dir -f tb.f

run: compile
	@out="$$(./obj_dir/Vtb_la32 +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
